// File: dv/controlUnit_vectors.txt
# ir (hex)  cond  moc low cycles  execute cycles
# class is ir[27:25], branch link is ir[20]
E0810002 1 0 2
E2811001 1 1 1
EA000004 1 2 2
EA100004 1 0 3
E5912000 1 1 0
E7912003 1 3 0
E0810002 0 1 0
EA100008 0 0 0
E2811001 0 2 0
E8900003 1 1 0
EC000000 1 0 0
E3B00001 1 4 1
E0100002 1 2 2
EB000010 1 1 2
EE000000 1 0 0

// File: controlUnit.f
src/ctrlPkg.sv
src/ctrlWordIf.sv
src/instrDecoder.sv
src/controlSequencer.sv
src/controlWordEncoder.sv
src/controlUnit.sv
dv/controlUnitTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module controlUnitTb \
	-f controlUnit.f -o controlUnitTb

./obj_dir/controlUnitTb 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST OK" sim.log; then
	exit 1
fi
exit 0

// File: dv/controlUnitTb.sv
`timescale 1ns/1ns

module controlUnitTb;
	import ctrlPkg::*;

	localparam int clkPeriod = 10;
	localparam int resetCycles = 3;
	localparam string vectorPath = "dv/controlUnit_vectors.txt";

	logic CLK;
	logic CLR;
	wordT ir;
	logic cond;
	logic moc;
	logic rfLd, irLd, marLd, rw, mov, frLd;
	muxSel2T ma, mb, mf, mj;
	muxSel3T mc;
	logic md, mh, mi, e;
	shiftTypeT t;
	shiftSelT s;
	aluOpT op;

	wordT vecIr[$];
	int vecCond[$];
	int vecMoc[$];
	int vecExec[$];
	integer seed;
	int timeLimit = 0;

	controlUnit controlUnit_i
	(
		.CLK(CLK), .CLR(CLR), .ir(ir), .cond(cond), .moc(moc),
		.rfLd(rfLd), .irLd(irLd), .marLd(marLd), .rw(rw), .mov(mov), .frLd(frLd),
		.ma(ma), .mb(mb), .mf(mf), .mj(mj), .mc(mc), .md(md), .mh(mh), .mi(mi),
		.e(e), .t(t), .s(s), .op(op)
	);

	always
	begin
		CLK = 1'b0;
		#(clkPeriod / 2);
		CLK = 1'b1;
		#(clkPeriod / 2);
	end

	// strobes are {rfLd, irLd, marLd, rw, mov, frLd}, dhi is {md, mh, mi}
	function automatic logic [ctrlWordBits-1:0] packWord(input logic [5:0] strobes,
		input int maV, input int mbV, input int mfV, input int mjV, input int mcV,
		input logic [2:0] dhi, input logic eV, input int tV, input int sV, input int opV);
		return {strobes, muxSel2T'(maV), muxSel2T'(mbV), muxSel2T'(mfV), muxSel2T'(mjV),
			muxSel3T'(mcV), dhi, eV, shiftTypeT'(tV), shiftSelT'(sV), aluOpT'(opV)};
	endfunction

	// expected control word per state
	function automatic logic [ctrlWordBits-1:0] refWord(input stateT st);
		case (st)
			FETCH_ADDR: return packWord(6'b001000, 2, 0, 0, 0, 0, 3'b100, 1'b0, 0, 0, 16);
			FETCH_INC: return packWord(6'b100110, 2, 0, 0, 0, 1, 3'b100, 1'b0, 0, 0, 17);
			FETCH_READ: return packWord(6'b010110, 0, 0, 0, 0, 0, 3'b000, 1'b0, 0, 0, 0);
			DP_SHIFT: return packWord(6'b100000, 0, 1, 0, 0, 4, 3'b100, 1'b1, 1, 0, 19);
			DP_WRITE_FLAGS: return packWord(6'b100001, 0, 0, 0, 1, 0, 3'b000, 1'b0, 0, 0, 0);
			DP_IMM: return packWord(6'b100001, 0, 1, 0, 0, 0, 3'b011, 1'b0, 0, 0, 0);
			BR_ADDR: return packWord(6'b100001, 0, 1, 3, 3, 4, 3'b100, 1'b1, 4, 0, 19);
			BR_TARGET: return packWord(6'b100000, 2, 0, 0, 1, 3, 3'b100, 1'b0, 0, 4, 4);
			BR_LINK: return packWord(6'b100000, 3, 0, 0, 1, 4, 3'b100, 1'b0, 0, 4, 4);
			default: return '0;
		endcase
	endfunction

	// name of the highest field that differs
	function automatic string fieldName(input logic [ctrlWordBits-1:0] diff);
		int idx;
		idx = 0;
		for (int i = 0; i < ctrlWordBits; i++)
		begin
			if (diff[i] !== 1'b0)
			begin
				idx = i;
			end
		end
		case (idx)
			34: return "rfLd";
			33: return "irLd";
			32: return "marLd";
			31: return "rw";
			30: return "mov";
			29: return "frLd";
			28, 27: return "ma";
			26, 25: return "mb";
			24, 23: return "mf";
			22, 21: return "mj";
			20, 19, 18: return "mc";
			17: return "md";
			16: return "mh";
			15: return "mi";
			14: return "e";
			13, 12, 11: return "t";
			10, 9, 8, 7, 6, 5: return "s";
			default: return "op";
		endcase
	endfunction

	task automatic checkWord(input stateT expSt);
		logic [ctrlWordBits-1:0] expW;
		logic [ctrlWordBits-1:0] actW;
		expW = refWord(expSt);
		actW = {rfLd, irLd, marLd, rw, mov, frLd, ma, mb, mf, mj, mc, md, mh, mi, e, t, s, op};
		assert (actW === expW)
		else
		begin
			$display("[FAIL] %0t ns: in %s field %s differs, expected word %h got %h", $time,
				expSt.name(), fieldName(actW ^ expW), expW, actW);
			$display("TEST FAILED");
			$fatal(1, "control word mismatch");
		end
	endtask

	// drive just after the edge, check on the falling edge
	task automatic runCycle(input stateT expSt, input wordT irVal, input logic condVal,
		input logic mocVal);
		@(posedge CLK);
		#1;
		ir = irVal;
		cond = condVal;
		moc = mocVal;
		@(negedge CLK);
		checkWord(expSt);
	endtask

	task automatic readVectors();
		int fd;
		int got;
		string line;
		wordT vIr;
		int vCond;
		int vMoc;
		int vExec;
		fd = $fopen(vectorPath, "r");
		if (fd == 0)
		begin
			$display("could not open the vector file %s", vectorPath);
			$display("TEST FAILED");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd))
		begin
			line = "";
			got = $fgets(line, fd);
			if (got > 0 && line.len() > 1 && line[0] != "#")
			begin
				got = $sscanf(line, "%h %d %d %d", vIr, vCond, vMoc, vExec);
				if (got != 4)
				begin
					$display("vector line could not be parsed: %s", line);
					$display("TEST FAILED");
					$fatal(1, "bad vector file");
				end
				vecIr.push_back(vIr);
				vecCond.push_back(vCond);
				vecMoc.push_back(vMoc);
				vecExec.push_back(vExec);
			end
		end
		$fclose(fd);
	endtask

	task automatic runInstr(input int n);
		stateT execSeq[$];
		int mocLow;
		wordT iw;
		logic c;
		iw = vecIr[n];
		c = vecCond[n][0];
		mocLow = vecMoc[n] + int'($unsigned($random(seed)) % 4);
		// execute states follow from the class field and the link bit
		if (c)
		begin
			case (iw[classMsb:classLsb])
				3'b000:
				begin
					execSeq.push_back(DP_SHIFT);
					execSeq.push_back(DP_WRITE_FLAGS);
				end
				3'b001: execSeq.push_back(DP_IMM);
				3'b101:
				begin
					if (iw[linkBit])
						execSeq.push_back(BR_LINK);
					execSeq.push_back(BR_ADDR);
					execSeq.push_back(BR_TARGET);
				end
				default: ;
			endcase
		end
		assert (execSeq.size() == vecExec[n])
		else
		begin
			$display("vector %0d lists %0d execute cycles but its class needs %0d", n,
				vecExec[n], execSeq.size());
			$display("TEST FAILED");
			$fatal(1, "inconsistent vector");
		end
		runCycle(FETCH_ADDR, iw, c, 1'b0);
		runCycle(FETCH_INC, iw, c, 1'b0);
		repeat (mocLow)
			runCycle(FETCH_READ, iw, c, 1'b0);
		runCycle(FETCH_READ, iw, c, 1'b1);
		runCycle(CHECK_COND, iw, c, 1'b0);
		foreach (execSeq[k])
			runCycle(execSeq[k], iw, c, 1'b0);
	endtask

	initial
	begin
		wait (timeLimit > 0);
		#(timeLimit);
		$display("simulation hung, watchdog expired after %0d ns", timeLimit);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	initial
	begin
		int cycles;
		CLR = 1'b0;
		ir = '0;
		cond = 1'b0;
		moc = 1'b0;
		seed = 32'haeb6_bf0b;
		readVectors();
		if (vecIr.size() == 0)
		begin
			$display("the vector file holds no vectors");
			$display("TEST FAILED");
			$fatal(1, "no stimulus");
		end
		cycles = resetCycles + 20;
		foreach (vecIr[n])
			cycles += 5 + vecMoc[n] + 3 + vecExec[n] + 3;
		timeLimit = cycles * clkPeriod;

		// outputs stay at zero through reset
		repeat (resetCycles)
		begin
			@(negedge CLK);
			checkWord(IDLE);
		end
		@(posedge CLK);
		#1;
		CLR = 1'b1;
		@(negedge CLK);
		checkWord(IDLE);

		for (int n = 0; n < vecIr.size(); n++)
			runInstr(n);
		runCycle(FETCH_ADDR, '0, 1'b0, 1'b0);
		$display("TEST OK");
		$finish;
	end

endmodule

// File: src/controlUnit.sv
`timescale 1ns/1ns

module controlUnit
(
	input logic CLK,
	input logic CLR,
	input ctrlPkg::wordT ir,
	input logic cond,
	input logic moc,
	output logic rfLd,
	output logic irLd,
	output logic marLd,
	output logic rw,
	output logic mov,
	output logic frLd,
	output ctrlPkg::muxSel2T ma,
	output ctrlPkg::muxSel2T mb,
	output ctrlPkg::muxSel2T mf,
	output ctrlPkg::muxSel2T mj,
	output ctrlPkg::muxSel3T mc,
	output logic md,
	output logic mh,
	output logic mi,
	output logic e,
	output ctrlPkg::shiftTypeT t,
	output ctrlPkg::shiftSelT s,
	output ctrlPkg::aluOpT op
);
	import ctrlPkg::*;

	stateT entryState;
	stateT state;

	ctrlWordIf ctrlBus (.CLK(CLK));

	instrDecoder decoder_i
	(
		.ir(ir),
		.entryState(entryState)
	);

	controlSequencer sequencer_i
	(
		.CLK(CLK),
		.CLR(CLR),
		.cond(cond),
		.moc(moc),
		.entryState(entryState),
		.state(state)
	);

	controlWordEncoder encoder_i
	(
		.state(state),
		.ctrl(ctrlBus.encoder)
	);

	// datapath side of the control word
	assign rfLd = ctrlBus.rfLd;
	assign irLd = ctrlBus.irLd;
	assign marLd = ctrlBus.marLd;
	assign rw = ctrlBus.rw;
	assign mov = ctrlBus.mov;
	assign frLd = ctrlBus.frLd;
	assign ma = ctrlBus.ma;
	assign mb = ctrlBus.mb;
	assign mf = ctrlBus.mf;
	assign mj = ctrlBus.mj;
	assign mc = ctrlBus.mc;
	assign md = ctrlBus.md;
	assign mh = ctrlBus.mh;
	assign mi = ctrlBus.mi;
	assign e = ctrlBus.e;
	assign t = ctrlBus.t;
	assign s = ctrlBus.s;
	assign op = ctrlBus.op;

endmodule

// File: src/controlWordEncoder.sv
`timescale 1ns/1ns

module controlWordEncoder
(
	input ctrlPkg::stateT state,
	ctrlWordIf.encoder ctrl
);
	import ctrlPkg::*;

	always_comb
	begin
		ctrl.rfLd = 1'b0;
		ctrl.irLd = 1'b0;
		ctrl.marLd = 1'b0;
		ctrl.rw = 1'b0;
		ctrl.mov = 1'b0;
		ctrl.frLd = 1'b0;
		ctrl.ma = '0;
		ctrl.mb = '0;
		ctrl.mf = '0;
		ctrl.mj = '0;
		ctrl.mc = '0;
		ctrl.md = 1'b0;
		ctrl.mh = 1'b0;
		ctrl.mi = 1'b0;
		ctrl.e = 1'b0;
		ctrl.t = '0;
		ctrl.s = '0;
		ctrl.op = '0;
		case (state)
			// PC to MAR
			FETCH_ADDR:
			begin
				ctrl.marLd = 1'b1;
				ctrl.ma = muxSel2T'(2);
				ctrl.md = 1'b1;
				ctrl.op = aluOpT'(16);
			end
			// PC + 4 while memory read starts
			FETCH_INC:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.rw = 1'b1;
				ctrl.mov = 1'b1;
				ctrl.ma = muxSel2T'(2);
				ctrl.mc = muxSel3T'(1);
				ctrl.md = 1'b1;
				ctrl.op = aluOpT'(17);
			end
			FETCH_READ:
			begin
				ctrl.irLd = 1'b1;
				ctrl.rw = 1'b1;
				ctrl.mov = 1'b1;
			end
			DP_SHIFT:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.mb = muxSel2T'(1);
				ctrl.mc = muxSel3T'(4);
				ctrl.md = 1'b1;
				ctrl.t = shiftTypeT'(1);
				ctrl.e = 1'b1;
				ctrl.op = aluOpT'(19);
			end
			DP_WRITE_FLAGS:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.frLd = 1'b1;
				ctrl.mj = muxSel2T'(1);
			end
			DP_IMM:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.frLd = 1'b1;
				ctrl.mb = muxSel2T'(1);
				ctrl.mh = 1'b1;
				ctrl.mi = 1'b1;
			end
			// offset through the shifter
			BR_ADDR:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.frLd = 1'b1;
				ctrl.mb = muxSel2T'(1);
				ctrl.mc = muxSel3T'(4);
				ctrl.md = 1'b1;
				ctrl.mf = muxSel2T'(3);
				ctrl.mj = muxSel2T'(3);
				ctrl.e = 1'b1;
				ctrl.t = shiftTypeT'(4);
				ctrl.op = aluOpT'(19);
			end
			BR_TARGET:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.ma = muxSel2T'(2);
				ctrl.mc = muxSel3T'(3);
				ctrl.md = 1'b1;
				ctrl.mj = muxSel2T'(1);
				ctrl.s = shiftSelT'(4);
				ctrl.op = aluOpT'(4);
			end
			// return address into the link register
			BR_LINK:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.ma = muxSel2T'(3);
				ctrl.mc = muxSel3T'(4);
				ctrl.md = 1'b1;
				ctrl.mj = muxSel2T'(1);
				ctrl.s = shiftSelT'(4);
				ctrl.op = aluOpT'(4);
			end
			default:
			begin
				// IDLE and CHECK_COND drive nothing
			end
		endcase
	end

	// memory cycle needs mov along with rw
	rwNeedsMov: assert property (@(posedge ctrl.CLK) ctrl.rw |-> ctrl.mov)
		else $error("rw without mov");

	// ir and register file share the memory data path
	irRfExclusive: assert property (@(posedge ctrl.CLK) !(ctrl.irLd && ctrl.rfLd))
		else $error("irLd and rfLd high together");

endmodule

// File: src/controlSequencer.sv
`timescale 1ns/1ns

module controlSequencer
(
	input logic CLK,
	input logic CLR,
	input logic cond,
	input logic moc,
	input ctrlPkg::stateT entryState,
	output ctrlPkg::stateT state
);
	import ctrlPkg::*;

	stateT nextState;

	always_ff @(posedge CLK or negedge CLR)
	begin
		if (!CLR)
		begin
			state <= IDLE;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_comb
	begin
		case (state)
			IDLE:
			begin
				nextState = FETCH_ADDR;
			end
			FETCH_ADDR:
			begin
				nextState = FETCH_INC;
			end
			FETCH_INC:
			begin
				nextState = FETCH_READ;
			end
			// hold the read until memory is done
			FETCH_READ:
			begin
				if (moc)
				begin
					nextState = CHECK_COND;
				end
				else
				begin
					nextState = FETCH_READ;
				end
			end
			// failed condition skips execution
			CHECK_COND:
			begin
				if (cond)
				begin
					nextState = entryState;
				end
				else
				begin
					nextState = FETCH_ADDR;
				end
			end
			DP_SHIFT:
			begin
				nextState = DP_WRITE_FLAGS;
			end
			BR_LINK:
			begin
				nextState = BR_ADDR;
			end
			BR_ADDR:
			begin
				nextState = BR_TARGET;
			end
			// DP_WRITE_FLAGS, DP_IMM and BR_TARGET all end the instruction
			default:
			begin
				nextState = FETCH_ADDR;
			end
		endcase
	end

	stateLegal: assert property (@(posedge CLK) disable iff (!CLR)
		state inside {IDLE, FETCH_ADDR, FETCH_INC, FETCH_READ, CHECK_COND, DP_SHIFT,
			DP_WRITE_FLAGS, DP_IMM, BR_ADDR, BR_TARGET, BR_LINK})
		else $error("state register holds an undeclared code");

	readWaits: assert property (@(posedge CLK) disable iff (!CLR)
		(state == FETCH_READ && !moc) |=> (state == FETCH_READ))
		else $error("left FETCH_READ before moc");

	condSkips: assert property (@(posedge CLK) disable iff (!CLR)
		(state == CHECK_COND && !cond) |=> (state == FETCH_ADDR))
		else $error("executed with cond low");

endmodule

// File: src/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder
(
	input ctrlPkg::wordT ir,
	output ctrlPkg::stateT entryState
);
	import ctrlPkg::*;

	instrClassT iClass;
	logic link;

	// codes 100, 110 and 111 fall outside the enum and hit the default arm
	assign iClass = instrClassT'(ir[classMsb:classLsb]);

	// bit 20 only means link for branches
	assign link = (iClass == BRANCH) && ir[linkBit];

	always_comb
	begin
		case (iClass)
			DATA_SHIFT:
			begin
				entryState = DP_SHIFT;
			end
			DATA_IMM:
			begin
				entryState = DP_IMM;
			end
			BRANCH:
			begin
				if (link)
				begin
					entryState = BR_LINK;
				end
				else
				begin
					entryState = BR_ADDR;
				end
			end
			// load/store not implemented, go fetch the next one
			LS_IMM, LS_REG:
			begin
				entryState = FETCH_ADDR;
			end
			default:
			begin
				entryState = FETCH_ADDR;
			end
		endcase
	end

endmodule

// File: src/ctrlWordIf.sv
`timescale 1ns/1ns

interface ctrlWordIf (input logic CLK);
	import ctrlPkg::*;

	// register and memory strobes
	logic rfLd;
	logic irLd;
	logic marLd;
	logic rw;
	logic mov;
	logic frLd;

	// datapath selects
	muxSel2T ma;
	muxSel2T mb;
	muxSel2T mf;
	muxSel2T mj;
	muxSel3T mc;
	logic md;
	logic mh;
	logic mi;

	// shifter and ALU
	logic e;
	shiftTypeT t;
	shiftSelT s;
	aluOpT op;

	// clock is only sampled by checks on the encoder side
	modport encoder
	(
		input CLK,
		output rfLd, irLd, marLd, rw, mov, frLd,
		output ma, mb, mf, mj, mc, md, mh, mi,
		output e, t, s, op
	);

	modport datapath
	(
		input rfLd, irLd, marLd, rw, mov, frLd,
		input ma, mb, mf, mj, mc, md, mh, mi,
		input e, t, s, op
	);

endinterface

// File: src/ctrlPkg.sv
package ctrlPkg;

	// instruction field positions
	localparam int classMsb = 27;
	localparam int classLsb = 25;
	localparam int linkBit = 20;

	localparam int wordBits = 32;

	// control field widths
	localparam int aluOpBits = 5;
	localparam int shiftSelBits = 6;
	localparam int shiftTypeBits = 3;
	localparam int mux2Bits = 2;
	localparam int mux3Bits = 3;

	// six load/strobe bits, md/mh/mi and e are single bits
	localparam int ctrlWordBits = 6
		+ 4 * mux2Bits
		+ mux3Bits
		+ 3
		+ 1
		+ shiftTypeBits
		+ shiftSelBits
		+ aluOpBits;

	typedef logic [wordBits-1:0] wordT;
	typedef logic [aluOpBits-1:0] aluOpT;
	typedef logic [shiftSelBits-1:0] shiftSelT;
	typedef logic [shiftTypeBits-1:0] shiftTypeT;
	typedef logic [mux2Bits-1:0] muxSel2T;
	typedef logic [mux3Bits-1:0] muxSel3T;

	// one code per clock state of the multicycle sequence
	typedef enum logic [3:0]
	{
		IDLE = 4'd0,
		FETCH_ADDR = 4'd1,
		FETCH_INC = 4'd2,
		FETCH_READ = 4'd3,
		CHECK_COND = 4'd4,
		DP_SHIFT = 4'd5,
		DP_WRITE_FLAGS = 4'd6,
		DP_IMM = 4'd7,
		BR_ADDR = 4'd8,
		BR_TARGET = 4'd9,
		BR_LINK = 4'd10
	} stateT;

	// class field, ir[27:25]
	typedef enum logic [2:0]
	{
		DATA_SHIFT = 3'b000,
		DATA_IMM = 3'b001,
		LS_IMM = 3'b010,
		LS_REG = 3'b011,
		BRANCH = 3'b101
	} instrClassT;

endpackage
